// File: Bender.yml
package:
  name: cpucore

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpuPkg.sv
      - logic/instrDecode.sv
      - logic/regFile.sv
      - logic/aluUnit.sv
      - logic/flagBranch.sv
      - logic/cpuCore.sv
  - target: test
    include_dirs:
      - logic
      - tests
    files:
      - tests/coreTb.sv

// File: logic/aluUnit.sv
`timescale 1ns/1ns
`include "cpuCfg.svh"

module aluUnit
  import cpuPkg::*;
(
  input  logic [`DATA_W-1:0] p0Data,
  input  logic [`DATA_W-1:0] p1Data,
  input  logic [11:0]        imm,
  input  logic [`REG_AW-1:0] shamt,
  input  aluOpT              aluOp,
  input  logic               aluSrc0,
  input  logic               aluSrc1,
  output logic [`DATA_W-1:0] result,
  output logic               ovOut,
  output logic               zrOut,
  output logic               neOut
);

  logic [`DATA_W-1:0] opA;
  logic [`DATA_W-1:0] opB;
  logic [`DATA_W-1:0] sum;
  logic [`DATA_W-1:0] diff;
  logic               sumOv;
  logic               diffOv;

  // Operand A is the byte immediate for llb and lhb
  assign opA = aluSrc0 ? {{(`DATA_W-8){imm[7]}}, imm[7:0]} : p0Data;
  // Operand B is the 4-bit memory offset for lw and sw
  assign opB = aluSrc1 ? {{(`DATA_W-4){imm[3]}}, imm[3:0]} : p1Data;

  // Both wrap at 16 bits
  assign sum  = opA + opB;
  assign diff = opA - opB;

  // Same-sign operands giving an opposite-sign sum
  assign sumOv = (opA[`DATA_W-1] == opB[`DATA_W-1]) &&
                 (sum[`DATA_W-1] != opA[`DATA_W-1]);
  // Mixed signs where the difference flips away from A
  assign diffOv = (opA[`DATA_W-1] != opB[`DATA_W-1]) &&
                  (diff[`DATA_W-1] != opA[`DATA_W-1]);

  always_comb begin
    ovOut = 1'b0;
    case (aluOp)
      aluAdd: begin
        result = sum;
        ovOut  = sumOv;
      end
      aluSub: begin
        result = diff;
        ovOut  = diffOv;
      end
      // New high byte over the kept low byte
      aluLhb: result = {imm[7:0], p0Data[`DATA_W-9:0]};
      aluAnd: result = opA & opB;
      aluNor: result = ~(opA | opB);
      aluSll: result = opA << shamt;
      aluSrl: result = opA >> shamt;
      aluSra: result = $signed(opA) >>> shamt;
      default: result = '0;
    endcase
  end

  assign zrOut = (result == '0);
  assign neOut = result[`DATA_W-1];

endmodule

// File: logic/cpuCfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Width of data words, registers and instructions
`define DATA_W 16

// Register file depth and its address width
`define REG_N 16
`define REG_AW 4

// Instruction and data memories are word indexed
`define PC_W 16

// First fetch address after reset
`define RESET_PC 0

// jal writes its return address here
`define LINK_REG 15

`endif

// File: logic/cpuCore.sv
`timescale 1ns/1ns
`include "cpuCfg.svh"

module cpuCore
  import cpuPkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  logic [`DATA_W-1:0] instr,
  input  logic [`DATA_W-1:0] dataRdata,
  output logic [`PC_W-1:0]   instrAddr,
  output logic [`PC_W-1:0]   dataAddr,
  output logic [`DATA_W-1:0] dataWdata,
  output logic               dataWe,
  output logic               dataRe,
  output logic               halted
);

  // Decoded fields and strobes
  logic [11:0]        imm;
  logic [`REG_AW-1:0] p0Addr;
  logic [`REG_AW-1:0] p1Addr;
  logic [`REG_AW-1:0] regAddr;
  logic [`REG_AW-1:0] shamt;
  aluOpT              aluOp;
  branchCondT         branchOp;
  logic               regWe;
  logic               memRe;
  logic               memWe;
  logic               addz;
  logic               branch;
  logic               jal;
  logic               jr;
  logic               halt;
  logic               aluSrc0;
  logic               aluSrc1;
  logic               ovEn;
  logic               zrEn;
  logic               neEn;

  // Datapath
  logic [`DATA_W-1:0] p0Data;
  logic [`DATA_W-1:0] p1Data;
  logic [`DATA_W-1:0] result;
  logic               ovOut;
  logic               zrOut;
  logic               neOut;
  logic [`PC_W-1:0]   pcPlusOne;
  logic               zeroFlag;
  logic [`DATA_W-1:0] wbData;
  logic               regWrEn;

  instrDecode uDecode (
    .instr, .imm, .p0Addr, .p1Addr, .regAddr, .shamt, .aluOp, .branchOp,
    .regWe, .memRe, .memWe, .addz, .branch, .jal, .jr, .halt,
    .aluSrc0, .aluSrc1, .ovEn, .zrEn, .neEn
  );

  // addz commits only while Z is held set
  assign regWrEn = (regWe | (addz & zeroFlag)) & ~halted;

  // Load data, then link address, else the ALU
  always_comb begin
    if (memRe) begin
      wbData = dataRdata;
    end else if (jal) begin
      wbData = pcPlusOne;
    end else begin
      wbData = result;
    end
  end

  regFile uRegs (
    .clk, .arstN, .p0Addr, .p1Addr,
    .wrAddr (regAddr),
    .wrEn   (regWrEn),
    .wrData (wbData),
    .p0Data, .p1Data
  );

  aluUnit uAlu (
    .p0Data, .p1Data, .imm, .shamt, .aluOp, .aluSrc0, .aluSrc1,
    .result, .ovOut, .zrOut, .neOut
  );

  flagBranch uFlow (
    .clk, .arstN,
    .ovIn (ovOut),
    .zrIn (zrOut),
    .neIn (neOut),
    .ovEn, .zrEn, .neEn, .branch, .branchOp, .jal, .jr, .halt, .imm,
    .jrTarget (p0Data),
    .pc       (instrAddr),
    .pcPlusOne, .zeroFlag, .halted
  );

  // Memory ports
  assign dataAddr  = result;
  assign dataWdata = p1Data;
  // Memory sees no strobe while the core is held in reset or stopped
  assign dataWe = memWe & ~halted & arstN;
  assign dataRe = memRe & ~halted & arstN;

  // After halt the fetch address freezes
  haltQuiet: assert property (
    @(posedge clk) disable iff (!arstN) halted |=> $stable(instrAddr)
  ) else $error("cpuCore: fetch address moved after halt");

endmodule

// File: logic/cpuPkg.sv
package cpuPkg;

  // Major opcode, instr[15:12]
  typedef enum logic [3:0] {
    opAdd    = 4'b0000,
    opAddz   = 4'b0001,
    opSub    = 4'b0010,
    opAnd    = 4'b0011,
    opNor    = 4'b0100,
    opSll    = 4'b0101,
    opSrl    = 4'b0110,
    opSra    = 4'b0111,
    opLw     = 4'b1000,
    opSw     = 4'b1001,
    opLhb    = 4'b1010,
    opLlb    = 4'b1011,
    opBranch = 4'b1100,
    opJal    = 4'b1101,
    opJr     = 4'b1110,
    opHalt   = 4'b1111
  } opcodeT;

  // ALU functions follow the low three opcode bits
  // Slot 001 is free since addz runs as an add, so lhb takes it
  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluLhb = 3'b001,
    aluSub = 3'b010,
    aluAnd = 3'b011,
    aluNor = 3'b100,
    aluSll = 3'b101,
    aluSrl = 3'b110,
    aluSra = 3'b111
  } aluOpT;

  // Branch condition, instr[11:9] of a branch
  typedef enum logic [2:0] {
    condNe     = 3'b000,
    condEq     = 3'b001,
    condGt     = 3'b010,
    condLt     = 3'b011,
    condGe     = 3'b100,
    condLe     = 3'b101,
    condOv     = 3'b110,
    condAlways = 3'b111
  } branchCondT;

endpackage

// File: logic/flagBranch.sv
`timescale 1ns/1ns
`include "cpuCfg.svh"

module flagBranch
  import cpuPkg::*;
(
  input  logic             clk,
  input  logic             arstN,
  input  logic             ovIn,
  input  logic             zrIn,
  input  logic             neIn,
  input  logic             ovEn,
  input  logic             zrEn,
  input  logic             neEn,
  input  logic             branch,
  input  branchCondT       branchOp,
  input  logic             jal,
  input  logic             jr,
  input  logic             halt,
  input  logic [11:0]      imm,
  input  logic [`PC_W-1:0] jrTarget,
  output logic [`PC_W-1:0] pc,
  output logic [`PC_W-1:0] pcPlusOne,
  output logic             zeroFlag,
  output logic             halted
);

  logic             ovFlag;
  logic             zrFlag;
  logic             neFlag;
  logic             taken;
  logic [`PC_W-1:0] pcNext;

  assign pcPlusOne = pc + `PC_W'(1);
  assign zeroFlag  = zrFlag;

  // Conditions look at flags from earlier instructions only
  always_comb begin
    case (branchOp)
      condNe:     taken = ~zrFlag;
      condEq:     taken = zrFlag;
      condGt:     taken = ~zrFlag & ~neFlag;
      condLt:     taken = neFlag;
      condGe:     taken = zrFlag | ~neFlag;
      condLe:     taken = zrFlag | neFlag;
      condOv:     taken = ovFlag;
      condAlways: taken = 1'b1;
      default:    taken = 1'b0;
    endcase
  end

  // PC stays parked on the halt word, so the fetch address freezes
  always_comb begin
    if (halted || halt) begin
      pcNext = pc;
    end else if (branch && taken) begin
      pcNext = pcPlusOne + {{(`PC_W-9){imm[8]}}, imm[8:0]};
    end else if (jal) begin
      pcNext = pcPlusOne + {{(`PC_W-12){imm[11]}}, imm[11:0]};
    end else if (jr) begin
      pcNext = jrTarget;
    end else begin
      pcNext = pcPlusOne;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc     <= `PC_W'(`RESET_PC);
      halted <= 1'b0;
    end else begin
      pc     <= pcNext;
      // Sticky until the next reset
      halted <= halted | halt;
    end
  end

  // Each flag loads on its own enable, frozen after halt
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ovFlag <= 1'b0;
      zrFlag <= 1'b0;
      neFlag <= 1'b0;
    end else if (!halted) begin
      if (ovEn) ovFlag <= ovIn;
      if (zrEn) zrFlag <= zrIn;
      if (neEn) neFlag <= neIn;
    end
  end

  // The three PC redirects never coincide
  redirectOneHot: assert property (
    @(posedge clk) disable iff (!arstN) $onehot0({branch, jal, jr})
  ) else $error("flagBranch: more than one of branch, jal, jr");

endmodule

// File: logic/instrDecode.sv
`timescale 1ns/1ns
`include "cpuCfg.svh"

module instrDecode
  import cpuPkg::*;
(
  input  logic [`DATA_W-1:0] instr,
  output logic [11:0]        imm,
  output logic [`REG_AW-1:0] p0Addr,
  output logic [`REG_AW-1:0] p1Addr,
  output logic [`REG_AW-1:0] regAddr,
  output logic [`REG_AW-1:0] shamt,
  output aluOpT              aluOp,
  output branchCondT         branchOp,
  output logic               regWe,
  output logic               memRe,
  output logic               memWe,
  output logic               addz,
  output logic               branch,
  output logic               jal,
  output logic               jr,
  output logic               halt,
  output logic               aluSrc0,
  output logic               aluSrc1,
  output logic               ovEn,
  output logic               zrEn,
  output logic               neEn
);

  opcodeT opcode;
  logic   aluClass;
  logic   isAdd;
  logic   isSub;
  logic   isSw;
  logic   isLhb;
  logic   isLlb;

  assign opcode = opcodeT'(instr[15:12]);

  // Lower half of the opcode map is the ALU group
  assign aluClass = ~instr[15];

  // One-hot opcode matches
  assign isAdd  = (opcode == opAdd);
  assign isSub  = (opcode == opSub);
  assign isSw   = (opcode == opSw);
  assign isLhb  = (opcode == opLhb);
  assign isLlb  = (opcode == opLlb);
  assign addz   = (opcode == opAddz);
  assign branch = (opcode == opBranch);
  assign jal    = (opcode == opJal);
  assign jr     = (opcode == opJr);
  assign halt   = (opcode == opHalt);

  // Raw fields
  assign imm      = instr[11:0];
  assign shamt    = instr[3:0];
  assign branchOp = branchCondT'(instr[11:9]);

  // lhb reads its own destination so the low byte survives
  assign p0Addr = isLhb ? instr[11:8] : instr[7:4];

  // Store data and lhb come from the 11:8 field
  // llb adds its immediate to R0
  assign p1Addr = (isSw | isLhb) ? instr[11:8] :
                  isLlb          ? `REG_AW'(0) :
                                   instr[3:0];

  // Return address always lands in the link register
  assign regAddr = jal ? `REG_AW'(`LINK_REG) : instr[11:8];

  // addz writes conditionally, decided in the core
  assign regWe = ~(addz | isSw | branch | jr | halt);

  assign memRe = (opcode == opLw);
  assign memWe = isSw;

  // Arithmetic sets all flags, logic and shifts only Z
  assign ovEn = isAdd | addz | isSub;
  assign zrEn = aluClass;
  assign neEn = ovEn;

  // Byte loads feed imm[7:0] as operand A
  assign aluSrc0 = isLlb | isLhb;
  // Loads and stores add imm[3:0] as the offset
  assign aluSrc1 = memRe | memWe;

  always_comb begin
    if (aluClass) begin
      // addz is an add whose write-back is conditional
      aluOp = addz ? aluAdd : aluOpT'(instr[14:12]);
    end else if (isLhb) begin
      aluOp = aluLhb;
    end else begin
      // lw, sw and llb need an add, control ops ignore the ALU
      aluOp = aluAdd;
    end
  end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ns
`include "cpuCfg.svh"

module regFile (
  input  logic               clk,
  input  logic               arstN,
  input  logic [`REG_AW-1:0] p0Addr,
  input  logic [`REG_AW-1:0] p1Addr,
  input  logic [`REG_AW-1:0] wrAddr,
  input  logic               wrEn,
  input  logic [`DATA_W-1:0] wrData,
  output logic [`DATA_W-1:0] p0Data,
  output logic [`DATA_W-1:0] p1Data
);

  logic [`DATA_W-1:0] regs [`REG_N];
  logic               wrLive;

  // Writes aimed at R0 are discarded
  assign wrLive = wrEn && (wrAddr != '0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Asynchronous reads
  // A same-cycle write shows up only after the edge
  assign p0Data = (p0Addr == '0) ? '0 : regs[p0Addr];
  assign p1Data = (p1Addr == '0) ? '0 : regs[p1Addr];

endmodule

// File: project.f
+incdir+logic
+incdir+tests
logic/cpuPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluUnit.sv
logic/flagBranch.sv
logic/cpuCore.sv
tests/coreTb.sv

// File: tests/coreProgram.svh
`ifndef CORE_PROGRAM_SVH
`define CORE_PROGRAM_SVH

// Program words run from address 0
localparam int PROG_N = 79;
// The PC parks on the halt word
localparam int HALT_AT = 76;

localparam logic [15:0] PROG [PROG_N] = '{
  // Store base R14 is 0x40 and the operands are 5 and -3
  16'hBE40, 16'hB105, 16'hB2FD,
  // add wraps to 2 and each result is stored
  16'h0312, 16'h93E0, 16'h2412, 16'h94E1,
  16'h3512, 16'h95E2, 16'h4612, 16'h96E3,
  // Shifts by 4
  16'h5714, 16'h97E4, 16'h6824, 16'h98E5,
  16'h7924, 16'h99E6,
  // Write to R0 is lost so R0 stores as zero
  16'h0011, 16'h90E7,
  // Byte loads build 0xAB34 and 0xFF9C below the store base
  16'hBA34, 16'hAAAB, 16'hBB9C, 16'h9AE8, 16'h9BE9,
  // Loads through base R12 at offsets +3 and -2
  16'hBC10, 16'h81C3, 16'h82CE, 16'h91EA, 16'h92EB,
  // Z set by a sub of equal values
  16'h2055,
  // Each test loads marker 0x11 and branches over the 0x22 marker
  16'hBD11, 16'hC201, 16'hBD22, 16'h9DE0, // eq
  16'hBD11, 16'hC001, 16'hBD22, 16'h9DE0, // ne
  16'hBD11, 16'hCA01, 16'hBD22, 16'h9DE0, // le
  // N set by 0 minus 8
  16'h2004,
  16'hBD11, 16'hC601, 16'hBD22, 16'h9DE0, // lt
  16'hBD11, 16'hC801, 16'hBD22, 16'h9DE0, // ge
  16'hBD11, 16'hC401, 16'hBD22, 16'h9DE0, // gt
  // V set by 0x8002 minus 5
  16'hA680, 16'h2065,
  16'hBD11, 16'hCC01, 16'hBD22, 16'h9DE0, // ov
  16'hBD11, 16'hCE01, 16'hBD22, 16'h9DE0, // always
  // addz with Z clear keeps R7 and with Z set writes 10
  16'h1755, 16'h97E1, 16'h2055, 16'h1755, 16'h97E1,
  // jal links 71 and jumps to 72 where jr returns to 71
  16'hD001, 16'hCE02, 16'h9FE2, 16'hE0F0,
  16'hBD77, 16'h9DE3,
  // Halt then stores that never run
  16'hF000, 16'h93E0, 16'h94E1
};

localparam int STORE_N = 24;
// Entry holds a kind nibble then the store address then the data
// Kind 1 takes the data from the preload word at the data field address
localparam logic [35:0] STORES [STORE_N] = '{
  36'h0_0040_0002, 36'h0_0041_0008, 36'h0_0042_0005, 36'h0_0043_0002,
  36'h0_0044_0050, 36'h0_0045_0FFF, 36'h0_0046_FFFF, 36'h0_0047_0000,
  36'h0_0038_AB34, 36'h0_0039_FF9C,
  36'h1_003A_0013, 36'h1_003B_000E,
  // Branch markers for eq ne le lt ge gt ov always
  36'h0_0040_0011, 36'h0_0040_0022, 36'h0_0040_0011, 36'h0_0040_0011,
  36'h0_0040_0022, 36'h0_0040_0022, 36'h0_0040_0011, 36'h0_0040_0011,
  // addz kept then written and the link value then the return marker
  36'h0_0041_0050, 36'h0_0041_000A, 36'h0_0042_0047, 36'h0_0043_0077
};

`endif

// File: tests/coreTb.sv
`timescale 1ns/1ns
`include "cpuCfg.svh"

module coreTb;

  `include "coreProgram.svh"

  localparam int CYCLE_LIMIT = 4 * PROG_N + 20;
  localparam int DMEM_N = 256;

  logic               clk;
  logic               arstN;
  logic [`DATA_W-1:0] instr;
  logic [`DATA_W-1:0] dataRdata;
  logic [`PC_W-1:0]   instrAddr;
  logic [`PC_W-1:0]   dataAddr;
  logic [`DATA_W-1:0] dataWdata;
  logic               dataWe;
  logic               dataRe;
  logic               halted;

  logic [`DATA_W-1:0] rom [PROG_N];
  logic [`DATA_W-1:0] dataMem [DMEM_N];
  logic [`PC_W-1:0]   expAddr [STORE_N];
  logic [`DATA_W-1:0] expData [STORE_N];
  logic [`DATA_W-1:0] resetInstr;
  logic [31:0]        lcgState;
  logic [`PC_W-1:0]   parkedAddr;
  int                 storeIdx;
  int                 errCount;
  int                 cycles;

  cpuCore dut (
    .clk, .arstN, .instr, .dataRdata,
    .instrAddr, .dataAddr, .dataWdata, .dataWe, .dataRe, .halted
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Memory words sit on the bus during reset, fetches past the table return halt
  assign instr = !arstN              ? resetInstr :
                 (instrAddr < PROG_N) ? rom[instrAddr] :
                                        16'hF000;
  // Read data is only valid under the read strobe
  assign dataRdata = dataRe ? dataMem[dataAddr[7:0]] : 'x;

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic reportMismatch(input string name, input logic [`DATA_W-1:0] got,
                                input logic [`DATA_W-1:0] exp);
    $display("[ERROR] %s got %h expected %h", name, got, exp);
    errCount++;
  endtask

  task automatic checkStrobesIdle();
    if (dataWe !== 1'b0) begin
      reportMismatch("dataWe", dataWe, 0);
    end
    if (dataRe !== 1'b0) begin
      reportMismatch("dataRe", dataRe, 0);
    end
  endtask

  // Data memory write
  always @(posedge clk) begin
    if (dataWe) begin
      dataMem[dataAddr[7:0]] <= dataWdata;
    end
  end

  // Stores compared mid-cycle against the expected list
  always @(negedge clk) begin
    if (dataWe) begin
      if (storeIdx >= STORE_N) begin
        $display("Unexpected store to address %h with data %h", dataAddr, dataWdata);
        errCount++;
      end else begin
        if (dataAddr !== expAddr[storeIdx]) begin
          reportMismatch("dataAddr", dataAddr, expAddr[storeIdx]);
        end
        if (dataWdata !== expData[storeIdx]) begin
          reportMismatch("dataWdata", dataWdata, expData[storeIdx]);
        end
        storeIdx++;
      end
    end
  end

  initial begin
    arstN      = 1'b0;
    // A store word first, a load word later
    resetInstr = 16'h93E0;
    storeIdx   = 0;
    errCount   = 0;
    cycles     = 0;
    for (int i = 0; i < PROG_N; i++) begin
      rom[i] = PROG[i];
    end
    // Preload from the LCG
    lcgState = 32'd79782;
    for (int i = 0; i < DMEM_N; i++) begin
      lcgState   = lcgNext(lcgState);
      dataMem[i] = lcgState[31:16];
    end
    // Load results come from the preload
    for (int i = 0; i < STORE_N; i++) begin
      expAddr[i] = STORES[i][31:16];
      if (STORES[i][32]) begin
        expData[i] = dataMem[STORES[i][7:0]];
      end else begin
        expData[i] = STORES[i][15:0];
      end
    end
    // Memory strobes stay quiet in reset even for sw and lw words
    @(negedge clk);
    checkStrobesIdle();
    @(posedge clk);
    #2 resetInstr = 16'h81C3;
    @(negedge clk);
    checkStrobesIdle();
    @(negedge clk);
    checkStrobesIdle();
    @(posedge clk);
    #2 arstN = 1'b1;
    @(negedge clk);
    if (instrAddr !== `PC_W'(`RESET_PC)) reportMismatch("instrAddr", instrAddr, `RESET_PC);
    while (halted !== 1'b1 && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (halted !== 1'b1) begin
      $display("Timeout after %0d cycles because the core never halted", cycles);
      errCount++;
    end else begin
      if (instrAddr !== HALT_AT) reportMismatch("instrAddr", instrAddr, HALT_AT);
      parkedAddr = instrAddr;
      repeat (6) @(negedge clk);
      if (instrAddr !== parkedAddr) reportMismatch("instrAddr", instrAddr, parkedAddr);
    end
    if (storeIdx != STORE_N) begin
      $display("Missing stores since only %0d of %0d appeared", storeIdx, STORE_N);
      errCount++;
    end
    $display("%0d errors with %0d of %0d stores checked", errCount, storeIdx, STORE_N);
    if (errCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
